// ==== source/conv_accum_pkg.sv ====
`default_nettype none

package conv_accum_pkg;

  ////////////////////////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////////////////////////

  // Word width of pixels and partial sums
  localparam int DEF_DATA_WIDTH     = 32;

  // Pixels per map, raster order
  localparam int DEF_IMAGE_SIZE     = 16;

  // Input channels summed into one output map
  localparam int DEF_CHANNEL_NUM_IN = 4;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Which input channel is arriving
  // PH_MIDDLE covers channels 1 to CHANNEL_NUM_IN-2
  typedef enum logic [1:0] {
    PH_FIRST  = 2'd0,
    PH_MIDDLE = 2'd1,
    PH_LAST   = 2'd2
  } chan_phase_t;

  // Adder opcode
  // LOAD starts a new sum, ADD folds in the stored partial sum
  typedef enum logic {
    OP_LOAD = 1'b0,
    OP_ADD  = 1'b1
  } accum_op_t;

endpackage

`default_nettype wire

// ==== source/accum_control.sv ====
`default_nettype none

module accum_control #(
  parameter int  IMAGE_SIZE     = conv_accum_pkg::DEF_IMAGE_SIZE,
  parameter int  CHANNEL_NUM_IN = conv_accum_pkg::DEF_CHANNEL_NUM_IN,
  localparam int ADDR_WIDTH     = $clog2(IMAGE_SIZE)
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      valid_in,
  output conv_accum_pkg::accum_op_t op,
  output logic [ADDR_WIDTH-1:0]     rd_addr,
  output logic                      wr_en,
  output logic [ADDR_WIDTH-1:0]     wr_addr,
  output logic                      valid_out,
  output logic                      map_done
);

  import conv_accum_pkg::*;

  localparam int CHAN_WIDTH = $clog2(CHANNEL_NUM_IN);

  localparam logic [ADDR_WIDTH-1:0] LAST_PIXEL  = ADDR_WIDTH'(IMAGE_SIZE - 1);
  localparam logic [CHAN_WIDTH-1:0] LAST_CHAN   = CHAN_WIDTH'(CHANNEL_NUM_IN - 1);
  localparam logic [CHAN_WIDTH-1:0] LAST_MIDDLE = CHAN_WIDTH'(CHANNEL_NUM_IN - 2);

  logic [ADDR_WIDTH-1:0] pix_cnt;
  logic [CHAN_WIDTH-1:0] chan_cnt;
  chan_phase_t           phase;
  chan_phase_t           phase_next;
  logic                  pix_wrap;

  // Stage 1 copies of the stage 0 controls
  logic                  valid_s1;
  logic [ADDR_WIDTH-1:0] addr_s1;
  logic                  last_chan_s1;
  logic                  last_pixel_s1;

  ////////////////////////////////////////////////////////////
  // Stage 0 counters and channel phase
  ////////////////////////////////////////////////////////////

  // Last pixel of the current channel map is arriving
  assign pix_wrap = valid_in && (pix_cnt == LAST_PIXEL);

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt <= '0;
    end else if (valid_in) begin
      if (pix_cnt == LAST_PIXEL) begin
        pix_cnt <= '0;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      chan_cnt <= '0;
    end else if (pix_wrap) begin
      if (chan_cnt == LAST_CHAN) begin
        chan_cnt <= '0;
      end else begin
        chan_cnt <= chan_cnt + 1'b1;
      end
    end
  end

  // Two channels only: no middle phase at all
  always_comb begin
    phase_next = phase;
    case (phase)
      PH_FIRST: begin
        phase_next = (CHANNEL_NUM_IN == 2) ? PH_LAST : PH_MIDDLE;
      end
      PH_MIDDLE: begin
        if (chan_cnt == LAST_MIDDLE) begin
          phase_next = PH_LAST;
        end
      end
      PH_LAST: begin
        phase_next = PH_FIRST;
      end
      default: begin
        phase_next = PH_FIRST;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= PH_FIRST;
    end else if (pix_wrap) begin
      phase <= phase_next;
    end
  end

  // Read of the stored partial sum starts with the pixel itself
  assign rd_addr = pix_cnt;
  assign op      = (phase == PH_FIRST) ? OP_LOAD : OP_ADD;

  ////////////////////////////////////////////////////////////
  // Stage 1 and 2 alignment with the datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    addr_s1       <= pix_cnt;
    last_chan_s1  <= (phase == PH_LAST);
    last_pixel_s1 <= (pix_cnt == LAST_PIXEL);
  end

  // Last channel goes out instead of back into the buffer
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en     <= 1'b0;
      valid_out <= 1'b0;
      map_done  <= 1'b0;
    end else begin
      wr_en     <= valid_s1 && !last_chan_s1;
      valid_out <= valid_s1 && last_chan_s1;
      map_done  <= valid_s1 && last_chan_s1 && last_pixel_s1;
    end
  end

  always_ff @(posedge clk) begin
    wr_addr <= addr_s1;
  end

endmodule

`default_nettype wire

// ==== source/psum_buffer.sv ====
`default_nettype none

module psum_buffer #(
  parameter int  DATA_WIDTH = conv_accum_pkg::DEF_DATA_WIDTH,
  parameter int  IMAGE_SIZE = conv_accum_pkg::DEF_IMAGE_SIZE,
  localparam int ADDR_WIDTH = $clog2(IMAGE_SIZE)
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic [DATA_WIDTH-1:0] rd_data
);

  ////////////////////////////////////////////////////////////
  // One map of running sums, indexed by pixel
  ////////////////////////////////////////////////////////////

  logic [DATA_WIDTH-1:0] mem [IMAGE_SIZE];

  // Write port, driven two cycles behind the read of the same pixel
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port
  // data lines up with the pixel held in the adder's first stage
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== source/psum_adder.sv ====
`default_nettype none

module psum_adder #(
  parameter int DATA_WIDTH = conv_accum_pkg::DEF_DATA_WIDTH
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [DATA_WIDTH-1:0]     pxl_in,
  input  conv_accum_pkg::accum_op_t op,
  input  logic [DATA_WIDTH-1:0]     psum,
  output logic [DATA_WIDTH-1:0]     sum
);

  import conv_accum_pkg::*;

  logic [DATA_WIDTH-1:0] pxl_s1;
  accum_op_t             op_s1;
  logic [DATA_WIDTH-1:0] addend;

  ////////////////////////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////////////////////////

  // Hold pixel and opcode while the buffer read completes
  always_ff @(posedge clk) begin
    if (reset) begin
      pxl_s1 <= '0;
      op_s1  <= OP_LOAD;
    end else begin
      pxl_s1 <= pxl_in;
      op_s1  <= op;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2
  ////////////////////////////////////////////////////////////

  // First channel starts from zero, stale buffer data is dropped
  assign addend = (op_s1 == OP_ADD) ? psum : '0;

  // Two's complement add, carry out discarded
  always_ff @(posedge clk) begin
    if (reset) begin
      sum <= '0;
    end else begin
      sum <= pxl_s1 + addend;
    end
  end

endmodule

`default_nettype wire

// ==== source/conv_channel_accum.sv ====
`default_nettype none

module conv_channel_accum #(
  parameter int DATA_WIDTH     = conv_accum_pkg::DEF_DATA_WIDTH,
  parameter int IMAGE_SIZE     = conv_accum_pkg::DEF_IMAGE_SIZE,
  parameter int CHANNEL_NUM_IN = conv_accum_pkg::DEF_CHANNEL_NUM_IN
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  logic [DATA_WIDTH-1:0] pxl_in,
  output logic [DATA_WIDTH-1:0] pxl_out,
  output logic                  valid_out,
  output logic                  map_done
);

  import conv_accum_pkg::*;

  localparam int ADDR_WIDTH = $clog2(IMAGE_SIZE);

  accum_op_t             op;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] rd_data;
  logic [DATA_WIDTH-1:0] sum;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  accum_control #(
    .IMAGE_SIZE    (IMAGE_SIZE),
    .CHANNEL_NUM_IN(CHANNEL_NUM_IN)
  ) accum_control_inst (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .op       (op),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .valid_out(valid_out),
    .map_done (map_done)
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  psum_buffer #(
    .DATA_WIDTH(DATA_WIDTH),
    .IMAGE_SIZE(IMAGE_SIZE)
  ) psum_buffer_inst (
    .clk    (clk),
    .rd_addr(rd_addr),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(sum),
    .rd_data(rd_data)
  );

  psum_adder #(
    .DATA_WIDTH(DATA_WIDTH)
  ) psum_adder_inst (
    .clk   (clk),
    .reset (reset),
    .pxl_in(pxl_in),
    .op    (op),
    .psum  (rd_data),
    .sum   (sum)
  );

  // Same register feeds the buffer and the output stream
  assign pxl_out = sum;

endmodule

`default_nettype wire

// ==== verif/conv_channel_accum_tb.sv ====
`default_nettype none

module conv_channel_accum_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import conv_accum_pkg::*;

  localparam int DATA_WIDTH     = DEF_DATA_WIDTH;
  localparam int IMAGE_SIZE     = DEF_IMAGE_SIZE;
  localparam int CHANNEL_NUM_IN = DEF_CHANNEL_NUM_IN;
  localparam int ADDR_WIDTH     = $clog2(IMAGE_SIZE);

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 8;
  localparam int PIPE_LATENCY    = 2;
  localparam int OUTPUT_MAPS     = 4;
  localparam int MAP_PIXELS      = IMAGE_SIZE * CHANNEL_NUM_IN;
  localparam int WATCHDOG_CYCLES = OUTPUT_MAPS * MAP_PIXELS * 2 + 200;

  localparam logic [ADDR_WIDTH-1:0] LAST_PIXEL = ADDR_WIDTH'(IMAGE_SIZE - 1);

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  valid_in;
  logic [DATA_WIDTH-1:0] pxl_in;
  logic [DATA_WIDTH-1:0] pxl_out;
  logic                  valid_out;
  logic                  map_done;

  // Reference model state
  logic [DATA_WIDTH-1:0] sums [IMAGE_SIZE];
  logic [ADDR_WIDTH-1:0] pix_idx;
  int                    chan_idx;
  logic [31:0]           lfsr_state;
  string                 test_name;
  int                    cycle = 0;

  // Expected output words, consumed in order by the checker
  logic [DATA_WIDTH-1:0] exp_data [$];
  logic                  exp_done [$];
  int                    exp_due [$];
  int                    exp_head = 0;

  conv_channel_accum #(
    .DATA_WIDTH    (DATA_WIDTH),
    .IMAGE_SIZE    (IMAGE_SIZE),
    .CHANNEL_NUM_IN(CHANNEL_NUM_IN)
  ) conv_channel_accum_inst (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .pxl_out  (pxl_out),
    .valid_out(valid_out),
    .map_done (map_done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////
  // Reporting and random numbers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////////////////////////

  // Called on the edge that drives the pixel, so valid_in is high in cycle + 1
  task automatic model_pixel(input logic [DATA_WIDTH-1:0] pix);
    if (chan_idx == 0) begin
      sums[pix_idx] = pix;
    end else begin
      sums[pix_idx] = sums[pix_idx] + pix;
    end
    if (chan_idx == CHANNEL_NUM_IN - 1) begin
      exp_data.push_back(sums[pix_idx]);
      exp_done.push_back(pix_idx == LAST_PIXEL);
      exp_due.push_back(cycle + 1 + PIPE_LATENCY);
    end
    if (pix_idx == LAST_PIXEL) begin
      pix_idx  = '0;
      chan_idx = (chan_idx == CHANNEL_NUM_IN - 1) ? 0 : chan_idx + 1;
    end else begin
      pix_idx = pix_idx + 1'b1;
    end
  endtask

  task automatic feed_pixels(input int count);
    logic [31:0] gap;
    logic [31:0] pix;
    int          i;
    for (i = 0; i < count; i++) begin
      @(posedge clk);
      draw_bits(2, gap);
      // One idle cycle at most before each pixel
      if (gap == 0) begin
        valid_in <= 1'b0;
        @(posedge clk);
      end
      draw_bits(DATA_WIDTH, pix);
      valid_in <= 1'b1;
      pxl_in   <= pix;
      model_pixel(pix);
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    valid_in <= 1'b0;
  endtask

  task automatic apply_reset(input int cycles);
    @(posedge clk);
    valid_in <= 1'b0;
    reset    <= 1'b1;
    pix_idx  = '0;
    chan_idx = 0;
    repeat (cycles) @(posedge clk);
    reset <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Output checker
  ////////////////////////////////////////////////////////////

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    logic exp_valid;
    exp_valid = (exp_head < exp_due.size()) && (exp_due[exp_head] == cycle);
    assert (valid_out === exp_valid)
      else report_mismatch("valid_out", 32'(exp_valid), 32'(valid_out));
    if (exp_valid) begin
      assert (pxl_out === exp_data[exp_head])
        else report_mismatch("pxl_out", exp_data[exp_head], pxl_out);
      assert (map_done === exp_done[exp_head])
        else report_mismatch("map_done", 32'(exp_done[exp_head]), 32'(map_done));
      exp_head++;
    end else begin
      assert (map_done === 1'b0)
        else report_mismatch("map_done", 32'd0, 32'(map_done));
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Run timed out after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] cut;
    int          cut_point;
    reset      = 1'b1;
    valid_in   = 1'b0;
    pxl_in     = '0;
    pix_idx    = '0;
    chan_idx   = 0;
    lfsr_state = 32'hb95c;
    test_name  = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // Maps 0 and 1 back to back
    test_name = "map_0";
    feed_pixels(MAP_PIXELS);
    test_name = "map_1";
    feed_pixels(MAP_PIXELS);

    // Map 2 cut off inside the middle channels
    test_name = "map_2_cut";
    draw_bits(5, cut);
    cut_point = IMAGE_SIZE + int'(cut) % (IMAGE_SIZE * (CHANNEL_NUM_IN - 2));
    feed_pixels(cut_point);
    apply_reset(2);

    test_name = "map_2";
    feed_pixels(MAP_PIXELS);
    test_name = "map_3";
    feed_pixels(MAP_PIXELS);
    go_idle();

    test_name = "drain";
    while (exp_head < exp_due.size()) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== conv_channel_accum.f ====
source/conv_accum_pkg.sv
source/accum_control.sv
source/psum_buffer.sv
source/psum_adder.sv
source/conv_channel_accum.sv
verif/conv_channel_accum_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module conv_channel_accum_tb \
  -f conv_channel_accum.f || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/Vconv_channel_accum_tb 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "TEST OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
